// File: Makefile
TOP := tb_sram_bridge

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sram_bridge_top.f $(wildcard logic/*.sv tb/*.sv include/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f sram_bridge_top.f --top-module $(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: include/sram_bridge_config.svh
`ifndef SRAM_BRIDGE_CONFIG_SVH
`define SRAM_BRIDGE_CONFIG_SVH

// ----------------------------------------
// Address map
// ----------------------------------------
`define SRAM_AW 20            // AHB byte address width

// ----------------------------------------
// Memory wait states
// ----------------------------------------
`define SRAM_READ_CYCLES  2   // Extra wait cycles in a read beat
`define SRAM_WRITE_CYCLES 2   // Write pulse count, reloaded on entry to the pulse
`define SRAM_TURN_CYCLES  2   // Idle cycles on a change of direction
`define SRAM_CNT_W        3   // Wait counter width, must hold the largest count

`endif

// File: logic/ahb_beat_splitter.sv
`timescale 1ns/1ps
`include "sram_bridge_config.svh"

module ahb_beat_splitter
(
  input  logic                           i_hclk,
  input  logic                           i_hresetn,
  input  sram_bridge_pkg::ahb_req_t      i_ahb,
  input  logic                           i_done,
  output sram_bridge_pkg::beat_req_t     o_beat,
  output sram_bridge_pkg::beat_ctl_t     o_ctl,
  output logic [`SRAM_AW-2:0]            o_addr,
  output logic                           o_hreadyout
);

  logic                             trans_valid;     // Address phase accepted
  logic                             reg_write;       // HWRITE in data phase
  logic                             reg_active;      // Data phase in progress
  logic                             reg_word;        // Word transfer in data phase
  sram_bridge_pkg::bus_state_e      reg_bstate;
  sram_bridge_pkg::bus_state_e      nxt_bstate;
  logic [`SRAM_AW-2:0]              reg_addr;        // Halfword address to memory
  logic [`SRAM_AW-2:0]              nxt_addr;
  sram_bridge_pkg::beat_req_t       nxt_beat;        // Early request to memory FSM
  logic                             reg_rd_req;      // Request of the previous cycle
  logic                             reg_wr_req;
  logic [1:0]                       reg_byte_mask;

  assign trans_valid = i_ahb.sel & i_ahb.ready & i_ahb.trans[1];   // NONSEQ or SEQ

  // ----------------------------------------
  // Data-phase capture
  // ----------------------------------------
  always_ff @(posedge i_hclk or negedge i_hresetn)
  begin
    if (!i_hresetn)
    begin
      reg_write  <= 1'b0;
      reg_active <= 1'b0;
      reg_word   <= 1'b0;
    end
    else if (i_ahb.ready)                    // Frozen while the bus stalls
    begin
      reg_write  <= i_ahb.write;
      reg_active <= trans_valid;
      reg_word   <= i_ahb.size[1];
    end
  end

  // ----------------------------------------
  // Bus FSM
  // ----------------------------------------
  always_comb
  begin
    nxt_bstate = reg_bstate;                 // Hold by default
    nxt_addr   = reg_addr;
    nxt_beat   = '0;
    case (reg_bstate)
      sram_bridge_pkg::bus_idle:
      begin
        if (trans_valid)                     // Only when the last transfer is over
        begin
          nxt_addr        = i_ahb.addr[`SRAM_AW-1:1];
          nxt_beat.rd_req = ~i_ahb.write;
          nxt_beat.wr_req = i_ahb.write;
          case (i_ahb.size[1:0])
            2'b00:                                          // Byte
              nxt_beat.byte_mask = {i_ahb.addr[0], ~i_ahb.addr[0]};
            2'b01:                                          // Halfword
              nxt_beat.byte_mask = 2'b11;
            default:                                        // Word starts with the lower half
            begin
              nxt_beat.byte_mask = 2'b11;
              nxt_addr[0]        = 1'b0;
              nxt_bstate         = sram_bridge_pkg::bus_word_hi;
            end
          endcase
        end
        else                                 // Keep the pending beat until done
        begin
          nxt_beat.rd_req    = reg_rd_req & ~i_done;
          nxt_beat.wr_req    = reg_wr_req & ~i_done;
          nxt_beat.byte_mask = reg_byte_mask;
        end
      end
      sram_bridge_pkg::bus_word_hi:
      begin
        nxt_beat.rd_req    = ~reg_write;     // Stays up across both beats
        nxt_beat.wr_req    = reg_write;
        nxt_beat.byte_mask = reg_byte_mask;
        if (i_done)                          // Lower beat finished
        begin
          nxt_addr[0] = 1'b1;                // Upper halfword
          nxt_bstate  = sram_bridge_pkg::bus_idle;
        end
      end
      default:
        nxt_bstate = sram_bridge_pkg::bus_idle;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_hresetn)
  begin
    if (!i_hresetn)
    begin
      reg_bstate    <= sram_bridge_pkg::bus_idle;
      reg_addr      <= '0;
      reg_rd_req    <= 1'b0;
      reg_wr_req    <= 1'b0;
      reg_byte_mask <= 2'b00;
    end
    else
    begin
      reg_bstate    <= nxt_bstate;
      reg_addr      <= nxt_addr;
      reg_rd_req    <= nxt_beat.rd_req;
      reg_wr_req    <= nxt_beat.wr_req;
      reg_byte_mask <= nxt_beat.byte_mask;
    end
  end

  assign o_beat = nxt_beat;                  // Taken straight from the next-state logic
  assign o_addr = reg_addr;

  assign o_ctl.active      = reg_active;
  assign o_ctl.half_sel    = reg_addr[0];                   // Halfword bit of HADDR
  assign o_ctl.capture_low = (reg_bstate == sram_bridge_pkg::bus_word_hi) & ~reg_write;
  assign o_ctl.word_read   = reg_word;                      // Word size in data phase

  // Ready when idle or when the last beat ends
  assign o_hreadyout = ~reg_active | ((reg_bstate == sram_bridge_pkg::bus_idle) & i_done);

  // A beat request must survive until the memory FSM reports done
  a_req_held: assert property (
    @(posedge i_hclk) disable iff (!i_hresetn)
    ((o_beat.rd_req | o_beat.wr_req) && !i_done) |=>
      ((o_beat.rd_req | o_beat.wr_req) || i_done)
  );

endmodule

// File: logic/sram_bridge_pkg.sv
`include "sram_bridge_config.svh"

package sram_bridge_pkg;

  // ----------------------------------------
  // FSM states
  // ----------------------------------------
  typedef enum logic
  {
    bus_idle    = 1'b0,   // Idle, single beat or last beat of a word
    bus_word_hi = 1'b1    // Lower beat of a word running, upper beat still to issue
  } bus_state_e;

  typedef enum logic [2:0]
  {
    mem_idle        = 3'b000,   // Bus parked, turnaround countdown
    mem_write_setup = 3'b001,   // Address and data setup before we_n
    mem_write_pulse = 3'b011,   // we_n low
    mem_write_hold  = 3'b010,   // Data hold after we_n rises
    mem_read        = 3'b100    // oe_n low, wait for access time
  } mem_state_e;

  // ----------------------------------------
  // Inter-module bundles
  // ----------------------------------------
  typedef struct packed {
    logic                sel;     // HSEL
    logic [`SRAM_AW-1:0] addr;    // HADDR
    logic [1:0]          trans;   // HTRANS
    logic [2:0]          size;    // HSIZE
    logic                write;   // HWRITE
    logic                ready;   // HREADY from the bus
  } ahb_req_t;

  typedef struct packed {
    logic       rd_req;      // Read beat wanted
    logic       wr_req;      // Write beat wanted
    logic [1:0] byte_mask;   // Bit 1 upper byte, bit 0 lower byte
  } beat_req_t;

  typedef struct packed {
    logic active;        // AHB data phase in progress
    logic half_sel;      // AHB halfword on the memory bus
    logic capture_low;   // Lower halfword of a word read
    logic word_read;     // Build HRDATA from the buffer
  } beat_ctl_t;

  typedef struct packed {
    logic ce_n;      // Chip enable
    logic oe_n;      // Output enable
    logic we_n;      // Write enable
    logic lb_n;      // Lower byte enable
    logic ub_n;      // Upper byte enable
    logic dq_oe_n;   // Bridge drives the data bus
  } sram_pins_t;

endpackage

// File: logic/sram_bridge_top.sv
`timescale 1ns/1ps
`include "sram_bridge_config.svh"

module sram_bridge_top
(
  input  logic                           HCLK,
  input  logic                           HRESETn,

  // AHB-Lite slave port
  input  sram_bridge_pkg::ahb_req_t      i_ahb,
  input  logic [31:0]                    i_hwdata,
  output logic                           o_hreadyout,
  output logic [31:0]                    o_hrdata,
  output logic                           o_hresp,

  // SRAM side, data bus split into two directions
  output logic [`SRAM_AW-2:0]            o_sram_addr,
  output sram_bridge_pkg::sram_pins_t    o_sram_pins,
  output logic [15:0]                    o_sram_dq,
  input  logic [15:0]                    i_sram_dq
);

  sram_bridge_pkg::beat_req_t    beat;   // Splitter to memory FSM
  sram_bridge_pkg::beat_ctl_t    ctl;    // Splitter to data path
  logic                          done;   // Beat complete

  assign o_hresp = 1'b0;                 // OKAY only

  ahb_beat_splitter u_splitter
  (
    .i_hclk      (HCLK),
    .i_hresetn   (HRESETn),
    .i_ahb       (i_ahb),
    .i_done      (done),
    .o_beat      (beat),
    .o_ctl       (ctl),
    .o_addr      (o_sram_addr),
    .o_hreadyout (o_hreadyout)
  );

  sram_timing_fsm u_timing
  (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .i_beat  (beat),
    .o_done  (done),
    .o_pins  (o_sram_pins)
  );

  sram_data_path u_data
  (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .i_ctl    (ctl),
    .i_done   (done),
    .i_hwdata (i_hwdata),
    .i_dq     (i_sram_dq),
    .o_dq     (o_sram_dq),
    .o_hrdata (o_hrdata)
  );

endmodule

// File: logic/sram_data_path.sv
`timescale 1ns/1ps

module sram_data_path
(
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  sram_bridge_pkg::beat_ctl_t    i_ctl,
  input  logic                          i_done,
  input  logic [31:0]                   i_hwdata,
  input  logic [15:0]                   i_dq,
  output logic [15:0]                   o_dq,
  output logic [31:0]                   o_hrdata
);

  logic [15:0] wr_half;      // Selected AHB halfword
  logic [15:0] reg_dq_out;   // Memory write data register
  logic [15:0] rd_buf;       // Lower halfword of a word read

  // ----------------------------------------
  // Write path
  // ----------------------------------------
  // Byte lanes stay in place, a byte write relies on lb_n and ub_n
  assign wr_half = i_ctl.half_sel ? i_hwdata[31:16] : i_hwdata[15:0];

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      reg_dq_out <= '0;
    else if (i_ctl.active)                   // HWDATA valid in data phase
      reg_dq_out <= wr_half;
  end

  assign o_dq = reg_dq_out;

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      rd_buf <= '0;
    else if (i_ctl.capture_low && i_done)    // End of the lower word beat
      rd_buf <= i_dq;
  end

  // Word read puts the second beat on top, others mirror the halfword
  assign o_hrdata = i_ctl.word_read ? {i_dq, rd_buf} : {i_dq, i_dq};

  // Buffered half must still belong to a word read when the upper beat runs
  a_capture_word: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (i_ctl.capture_low && i_done) |=> (i_ctl.word_read && i_ctl.active)
  );

endmodule

// File: logic/sram_timing_fsm.sv
`timescale 1ns/1ps
`include "sram_bridge_config.svh"

module sram_timing_fsm
(
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  sram_bridge_pkg::beat_req_t     i_beat,
  output logic                           o_done,
  output sram_bridge_pkg::sram_pins_t    o_pins
);

  localparam logic [`SRAM_CNT_W-1:0] READ_LOAD  = `SRAM_CNT_W'(`SRAM_READ_CYCLES);
  localparam logic [`SRAM_CNT_W-1:0] WRITE_LOAD = `SRAM_CNT_W'(`SRAM_WRITE_CYCLES);
  localparam logic [`SRAM_CNT_W-1:0] TURN_LOAD  = `SRAM_CNT_W'(`SRAM_TURN_CYCLES);

  sram_bridge_pkg::mem_state_e    reg_state;
  sram_bridge_pkg::mem_state_e    nxt_state;
  logic [`SRAM_CNT_W-1:0]         reg_cnt;       // Wait state counter
  logic [`SRAM_CNT_W-1:0]         nxt_cnt;
  logic [`SRAM_CNT_W-1:0]         dec_cnt;
  logic                           cnt_busy;      // Counter not yet zero
  logic                           last_op_wr;    // 1 = last beat was a write
  sram_bridge_pkg::sram_pins_t    reg_pins;
  sram_bridge_pkg::sram_pins_t    nxt_pins;

  assign dec_cnt  = reg_cnt - 1'b1;
  assign cnt_busy = (reg_cnt != '0);

  // ----------------------------------------
  // Memory FSM
  // ----------------------------------------
  always_comb
  begin
    nxt_state = reg_state;
    nxt_cnt   = reg_cnt;
    case (reg_state)
      sram_bridge_pkg::mem_idle:
      begin
        if (i_beat.rd_req)
        begin
          if (cnt_busy && last_op_wr)        // Turnaround after a write
            nxt_cnt = dec_cnt;
          else
          begin
            nxt_state = sram_bridge_pkg::mem_read;
            nxt_cnt   = READ_LOAD;
          end
        end
        else if (i_beat.wr_req)
        begin
          if (cnt_busy && !last_op_wr)       // Turnaround after a read
            nxt_cnt = dec_cnt;
          else
          begin
            nxt_state = sram_bridge_pkg::mem_write_setup;
            nxt_cnt   = WRITE_LOAD;
          end
        end
        else if (cnt_busy)                   // Let the turnaround run out
          nxt_cnt = dec_cnt;
      end
      sram_bridge_pkg::mem_read:
      begin
        if (cnt_busy)
          nxt_cnt = dec_cnt;
        else if (i_beat.rd_req)              // Read after read, no turnaround
          nxt_cnt = READ_LOAD;
        else
        begin
          nxt_state = sram_bridge_pkg::mem_idle;
          nxt_cnt   = TURN_LOAD;
        end
      end
      sram_bridge_pkg::mem_write_setup:
      begin
        nxt_state = sram_bridge_pkg::mem_write_pulse;
        nxt_cnt   = WRITE_LOAD;
      end
      sram_bridge_pkg::mem_write_pulse:
      begin
        if (cnt_busy)
          nxt_cnt = dec_cnt;
        else
          nxt_state = sram_bridge_pkg::mem_write_hold;
      end
      sram_bridge_pkg::mem_write_hold:
      begin
        if (i_beat.wr_req)                   // Write after write, no turnaround
        begin
          nxt_state = sram_bridge_pkg::mem_write_setup;
          nxt_cnt   = WRITE_LOAD;
        end
        else
        begin
          nxt_state = sram_bridge_pkg::mem_idle;
          nxt_cnt   = TURN_LOAD;
        end
      end
      default:
      begin
        nxt_state = sram_bridge_pkg::mem_idle;
        nxt_cnt   = '0;
      end
    endcase
  end

  // Beat ends on the last read wait or in the write hold cycle
  assign o_done = ((reg_state == sram_bridge_pkg::mem_read) && !cnt_busy) ||
                  (reg_state == sram_bridge_pkg::mem_write_hold);

  // ----------------------------------------
  // Pin decode from next state
  // ----------------------------------------
  always_comb
  begin
    nxt_pins = '1;                           // All inactive
    case (nxt_state)
      sram_bridge_pkg::mem_read:
      begin
        nxt_pins.ce_n = 1'b0;
        nxt_pins.oe_n = 1'b0;
        nxt_pins.lb_n = ~i_beat.byte_mask[0];
        nxt_pins.ub_n = ~i_beat.byte_mask[1];
      end
      sram_bridge_pkg::mem_write_setup,
      sram_bridge_pkg::mem_write_pulse,
      sram_bridge_pkg::mem_write_hold:
      begin
        nxt_pins.ce_n    = 1'b0;
        nxt_pins.dq_oe_n = 1'b0;             // Bridge owns the data bus
        nxt_pins.we_n    = (nxt_state != sram_bridge_pkg::mem_write_pulse);
        nxt_pins.lb_n    = ~i_beat.byte_mask[0];
        nxt_pins.ub_n    = ~i_beat.byte_mask[1];
      end
      default:
        nxt_pins = '1;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      reg_state  <= sram_bridge_pkg::mem_idle;
      reg_cnt    <= '0;
      reg_pins   <= '1;
      last_op_wr <= 1'b0;
    end
    else
    begin
      reg_state <= nxt_state;
      reg_cnt   <= nxt_cnt;
      reg_pins  <= nxt_pins;
      if (o_done)
        last_op_wr <= (reg_state == sram_bridge_pkg::mem_write_hold);
    end
  end

  assign o_pins = reg_pins;

  // Memory must never see a write while its outputs are on
  a_no_we_oe: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !(!o_pins.we_n && !o_pins.oe_n)
  );

endmodule

// File: sram_bridge_top.f
+incdir+include
logic/sram_bridge_pkg.sv
logic/ahb_beat_splitter.sv
logic/sram_timing_fsm.sv
logic/sram_data_path.sv
logic/sram_bridge_top.sv
tb/sram_model.sv
tb/tb_sram_bridge.sv

// File: tb/sram_model.sv
`timescale 1ns/1ps
`include "sram_bridge_config.svh"

module sram_model
(
  input  logic [`SRAM_AW-2:0]            i_addr,
  input  sram_bridge_pkg::sram_pins_t    i_pins,
  input  logic [15:0]                    i_dq,
  output logic [15:0]                    o_dq
);

  logic [15:0] mem [1 << (`SRAM_AW-1)];   // One entry per halfword address
  logic        we_n;                       // Write strobe, edge sensitive

  assign we_n = i_pins.we_n;

  // ----------------------------------------
  // Write on the rising edge of we_n
  // ----------------------------------------
  always @(posedge we_n)
  begin
    if (!i_pins.ce_n)
    begin
      if (!i_pins.lb_n)
        mem[i_addr][7:0] <= i_dq[7:0];     // Lower byte lane
      if (!i_pins.ub_n)
        mem[i_addr][15:8] <= i_dq[15:8];   // Upper byte lane
    end
  end

  // Whole halfword while selected, the bridge keeps the byte it needs
  assign o_dq = (!i_pins.ce_n && !i_pins.oe_n) ? mem[i_addr] : 16'h0000;

endmodule

// File: tb/tb_sram_bridge.sv
`timescale 1ns/1ps
`include "sram_bridge_config.svh"

module tb_sram_bridge;

  localparam int WAIT_LIMIT = 50;   // Cycles before a transfer counts as hung
  localparam int NUM_RAND   = 40;   // Random write and read pairs

  typedef struct packed {
    logic                write;
    logic [1:0]          size;    // 0 byte, 1 halfword, 2 word
    logic [`SRAM_AW-1:0] addr;
    logic [31:0]         wdata;
    logic [31:0]         rdata;   // Expected data for reads
  } stim_t;

  logic                          HCLK;
  logic                          HRESETn;
  logic                          hsel;
  logic [`SRAM_AW-1:0]           haddr;
  logic [1:0]                    htrans;
  logic [2:0]                    hsize;
  logic                          hwrite;
  logic [31:0]                   hwdata;
  sram_bridge_pkg::ahb_req_t     ahb_req;
  logic                          hreadyout;
  logic [31:0]                   hrdata;
  logic                          hresp;
  logic [`SRAM_AW-2:0]           sram_addr;
  sram_bridge_pkg::sram_pins_t   sram_pins;
  logic [15:0]                   sram_dq_out;     // Bridge to memory
  logic [15:0]                   sram_dq_in;      // Memory to bridge
  stim_t                         stim [$];
  logic [7:0]                    shadow [4096];   // Expected memory bytes over a 4 KB window
  logic [`SRAM_AW-1:0]           written [$];     // Word addresses written so far
  integer                        seed;

  always_comb
  begin
    ahb_req.sel   = hsel;
    ahb_req.addr  = haddr;
    ahb_req.trans = htrans;
    ahb_req.size  = hsize;
    ahb_req.write = hwrite;
    ahb_req.ready = hreadyout;    // HREADY follows HREADYOUT with a single slave
  end

  sram_bridge_top DUT
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_ahb       (ahb_req),
    .i_hwdata    (hwdata),
    .o_hreadyout (hreadyout),
    .o_hrdata    (hrdata),
    .o_hresp     (hresp),
    .o_sram_addr (sram_addr),
    .o_sram_pins (sram_pins),
    .o_sram_dq   (sram_dq_out),
    .i_sram_dq   (sram_dq_in)
  );

  sram_model u_sram
  (
    .i_addr (sram_addr),
    .i_pins (sram_pins),
    .i_dq   (sram_dq_out),
    .o_dq   (sram_dq_in)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;   // 40 ns period
  end

  // ----------------------------------------
  // Checks and expected values
  // ----------------------------------------
  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t ns: %s got %08h expected %08h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Bridge drives the data bus under a write strobe and releases it while the memory drives
  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      if (!sram_pins.we_n)
        check_value("dq_oe_n during write strobe", 32'(sram_pins.dq_oe_n), 32'h0);
      if (!sram_pins.oe_n)
        check_value("dq_oe_n during memory read", 32'(sram_pins.dq_oe_n), 32'h1);
    end
  end

  task automatic update_shadow(input logic [1:0] size, input logic [`SRAM_AW-1:0] addr,
                               input logic [31:0] data);
    logic [11:0] idx;
    int          n;
    idx = addr[11:0] & ~((12'd1 << size) - 12'd1);   // Align to the transfer size
    for (n = 0; n < (1 << size); n++)
    begin
      shadow[idx] = data[{idx[1:0], 3'b000} +: 8];   // AHB lane follows the address
      idx = idx + 12'd1;
    end
  endtask

  // Byte and halfword reads mirror the addressed halfword
  function automatic logic [31:0] shadow_read(input logic [1:0] size,
                                              input logic [`SRAM_AW-1:0] addr);
    logic [11:0] idx;
    logic [15:0] half;
    logic [31:0] result;
    idx    = {addr[11:1], 1'b0};
    half   = {shadow[idx + 12'd1], shadow[idx]};
    result = {half, half};
    if (size == 2'd2)
    begin
      idx    = {addr[11:2], 2'b00};
      result = {shadow[idx + 12'd3], shadow[idx + 12'd2], shadow[idx + 12'd1], shadow[idx]};
    end
    return result;
  endfunction

  // ----------------------------------------
  // AHB driver
  // ----------------------------------------
  task automatic bus_transfer(input logic write, input logic [1:0] size,
                              input logic [`SRAM_AW-1:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
    int cnt;
    @(negedge HCLK);                       // Address phase
    hsel   = 1'b1;
    htrans = 2'b10;                        // NONSEQ
    haddr  = addr;
    hsize  = {1'b0, size};
    hwrite = write;
    @(negedge HCLK);                       // Data phase
    hsel   = 1'b0;
    htrans = 2'b00;
    hwdata = write ? wdata : 32'h0;
    cnt    = 0;
    while (!hreadyout && cnt < WAIT_LIMIT)
    begin
      @(negedge HCLK);
      cnt++;
    end
    if (!hreadyout)
    begin
      $display("Timeout: HREADYOUT stayed low for %0d cycles at %0t ns", WAIT_LIMIT, $time);
      $display("CHECKS FAILED");
      $fatal(1, "Transfer did not complete");
    end
    rdata = hrdata;                        // Stable mid-cycle of the last beat
  endtask

  task automatic write_access(input logic [1:0] size, input logic [`SRAM_AW-1:0] addr,
                              input logic [31:0] data);
    logic [31:0] rd_ignored;
    bus_transfer(1'b1, size, addr, data, rd_ignored);
    update_shadow(size, addr, data);
  endtask

  task automatic read_access(input logic [1:0] size, input logic [`SRAM_AW-1:0] addr,
                             output logic [31:0] data);
    bus_transfer(1'b0, size, addr, 32'h0, data);
    check_value($sformatf("read size %0d at %05h", size, addr), data, shadow_read(size, addr));
  endtask

  task automatic add_entry(input logic write, input logic [1:0] size, input logic [11:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rdata);
    stim_t e;
    e.write = write;
    e.size  = size;
    e.addr  = `SRAM_AW'(addr);
    e.wdata = wdata;
    e.rdata = rdata;
    stim.push_back(e);
  endtask

  // ----------------------------------------
  // Directed table
  // ----------------------------------------
  task automatic load_table();
    add_entry(1'b1, 2'd2, 12'h040, 32'h1234_5678, 32'h0);            // Word split in two beats
    add_entry(1'b0, 2'd2, 12'h040, 32'h0, 32'h1234_5678);
    add_entry(1'b1, 2'd1, 12'h080, 32'hDEAD_BEEF, 32'h0);            // Halfword on the low lanes
    add_entry(1'b1, 2'd1, 12'h082, 32'hCAFE_5555, 32'h0);            // Halfword on the high lanes
    add_entry(1'b0, 2'd2, 12'h080, 32'h0, 32'hCAFE_BEEF);
    add_entry(1'b1, 2'd0, 12'h041, 32'h1122_3344, 32'h0);            // Lane 1 only
    add_entry(1'b1, 2'd0, 12'h043, 32'h9988_7766, 32'h0);            // Lane 3 only
    add_entry(1'b0, 2'd2, 12'h040, 32'h0, 32'h9934_3378);
    add_entry(1'b0, 2'd0, 12'h041, 32'h0, 32'h3378_3378);            // Byte reads mirror
    add_entry(1'b0, 2'd0, 12'h042, 32'h0, 32'h9934_9934);
    add_entry(1'b0, 2'd1, 12'h082, 32'h0, 32'hCAFE_CAFE);
    add_entry(1'b0, 2'd1, 12'h080, 32'h0, 32'hBEEF_BEEF);
    add_entry(1'b1, 2'd2, 12'h100, 32'h0F1E_2D3C, 32'h0);
    add_entry(1'b0, 2'd0, 12'h103, 32'h0, 32'h0F1E_0F1E);
  endtask

  initial
  begin
    int                  n;
    int                  pick;
    logic [31:0]         got;
    logic [31:0]         data;
    logic [`SRAM_AW-1:0] addr;
    seed    = 32'hbc60b3c8;
    HRESETn = 1'b0;
    hsel    = 1'b0;
    haddr   = '0;
    htrans  = 2'b00;
    hsize   = 3'b000;
    hwrite  = 1'b0;
    hwdata  = 32'h0;
    load_table();
    repeat (3) @(posedge HCLK);            // Reset held 3 cycles
    @(negedge HCLK);
    HRESETn = 1'b1;

    check_value("HREADYOUT after reset", 32'(hreadyout), 32'h1);
    check_value("HRESP after reset", 32'(hresp), 32'h0);
    check_value("SRAM enables after reset", 32'(sram_pins), 32'h3F);
    check_value("HRDATA after reset", hrdata, 32'h0);

    for (n = 0; n < stim.size(); n++)
    begin
      if (stim[n].write)
        write_access(stim[n].size, stim[n].addr, stim[n].wdata);
      else
      begin
        read_access(stim[n].size, stim[n].addr, got);
        check_value($sformatf("table entry %0d", n), got, stim[n].rdata);
      end
    end

    // Alternate directions so every access crosses a turnaround
    for (n = 0; n < NUM_RAND; n++)
    begin
      addr = `SRAM_AW'($random(seed)) & `SRAM_AW'(12'hFFC);
      data = $random(seed);
      write_access(2'd2, addr, data);
      written.push_back(addr);
      pick = int'($unsigned($random(seed)) % written.size());
      read_access(2'd2, written[pick], got);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
